// File: hdl/fft_cfg.svh
`ifndef FFT_CFG_SVH
`define FFT_CFG_SVH

// real or imaginary part of a sample.
`define FFT_WIDTH    16

// signed twiddle, 10 fractional bits.
`define FFT_TW_WIDTH 12

`define FFT_LOG2N    4
`define FFT_N        16

// 15 delay line + 4 butterfly + 2 twiddle + 1 output register.
`define FFT_LATENCY  22

`endif

// File: hdl/fft_sample_pkg.sv
`include "fft_cfg.svh"

package fft_sample_pkg;

   // one real or imaginary part of a complex sample.
   typedef logic signed [`FFT_WIDTH-1:0] sample_t;

   // one part of a twiddle factor, scaled by 2**(`FFT_TW_WIDTH-2).
   typedef logic signed [`FFT_TW_WIDTH-1:0] twiddle_t;

   // full product of a sample part and a twiddle part.
   typedef logic signed [`FFT_WIDTH+`FFT_TW_WIDTH-1:0] prod_t;

   // sum of two products, one growth bit.
   typedef logic signed [`FFT_WIDTH+`FFT_TW_WIDTH:0] acc_t;

endpackage

// File: hdl/fft_ctrl_pkg.sv
`include "fft_cfg.svh"

package fft_ctrl_pkg;

   // position of a sample inside its frame.
   typedef logic [`FFT_LOG2N-1:0] ctr_t;

   // butterfly stage number, 0 or 1.
   typedef logic [0:0] stage_t;

   // counts enabled cycles until the first frame reaches the output.
   typedef logic [$clog2(`FFT_LATENCY)-1:0] fill_t;

endpackage

// File: hdl/fft_bfi.sv
`timescale 1ns/1ns

module fft_bfi #(
   parameter int DELAY_LEN = 8
) (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  logic                    en_i,
   input  logic                    sel_i,
   input  fft_sample_pkg::sample_t x_re_i,
   input  fft_sample_pkg::sample_t x_im_i,
   output fft_sample_pkg::sample_t z_re_o,
   output fft_sample_pkg::sample_t z_im_o
);

   import fft_sample_pkg::*;

   sample_t dl_re [DELAY_LEN];
   sample_t dl_im [DELAY_LEN];
   sample_t old_re;
   sample_t old_im;
   sample_t fb_re;
   sample_t fb_im;
   sample_t sum_re;
   sample_t sum_im;

   assign old_re = dl_re[DELAY_LEN-1];  // partner from half a block ago.
   assign old_im = dl_im[DELAY_LEN-1];

   assign sum_re = old_re + x_re_i;
   assign sum_im = old_im + x_im_i;

   // difference goes back into the line and leaves in the next half block.
   assign fb_re = sel_i ? old_re - x_re_i : x_re_i;
   assign fb_im = sel_i ? old_im - x_im_i : x_im_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < DELAY_LEN; i++) begin
            dl_re[i] <= '0;
            dl_im[i] <= '0;
         end
         z_re_o <= '0;
         z_im_o <= '0;
      end else if (en_i) begin
         dl_re[0] <= fb_re;
         dl_im[0] <= fb_im;
         for (int i = 1; i < DELAY_LEN; i++) begin
            dl_re[i] <= dl_re[i-1];
            dl_im[i] <= dl_im[i-1];
         end
         if (sel_i) begin
            z_re_o <= sum_re;
            z_im_o <= sum_im;
         end else begin
            z_re_o <= old_re;  // drain the stored differences.
            z_im_o <= old_im;
         end
      end
   end

endmodule

// File: hdl/fft_bfii.sv
`timescale 1ns/1ns

module fft_bfii #(
   parameter int DELAY_LEN = 4
) (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  logic                    en_i,
   input  logic                    sel_i,
   input  logic                    tsel_i,
   input  fft_sample_pkg::sample_t x_re_i,
   input  fft_sample_pkg::sample_t x_im_i,
   output fft_sample_pkg::sample_t z_re_o,
   output fft_sample_pkg::sample_t z_im_o
);

   import fft_sample_pkg::*;

   sample_t dl_re [DELAY_LEN];
   sample_t dl_im [DELAY_LEN];
   logic    rot;
   sample_t in_re;
   sample_t in_im;
   sample_t old_re;
   sample_t old_im;
   sample_t fb_re;
   sample_t fb_im;
   sample_t sum_re;
   sample_t sum_im;

   // trivial twiddle -j on the odd partner of the difference half.
   // -j * (a + jb) = b - ja, so swap the parts and negate the new imaginary.
   assign rot   = tsel_i && sel_i;
   assign in_re = rot ? x_im_i : x_re_i;
   assign in_im = rot ? -x_re_i : x_im_i;

   assign old_re = dl_re[DELAY_LEN-1];
   assign old_im = dl_im[DELAY_LEN-1];

   assign sum_re = old_re + in_re;
   assign sum_im = old_im + in_im;

   assign fb_re = sel_i ? old_re - in_re : in_re;
   assign fb_im = sel_i ? old_im - in_im : in_im;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < DELAY_LEN; i++) begin
            dl_re[i] <= '0;
            dl_im[i] <= '0;
         end
         z_re_o <= '0;
         z_im_o <= '0;
      end else if (en_i) begin
         dl_re[0] <= fb_re;
         dl_im[0] <= fb_im;
         for (int i = 1; i < DELAY_LEN; i++) begin
            dl_re[i] <= dl_re[i-1];
            dl_im[i] <= dl_im[i-1];
         end
         if (sel_i) begin
            z_re_o <= sum_re;
            z_im_o <= sum_im;
         end else begin
            z_re_o <= old_re;
            z_im_o <= old_im;
         end
      end
   end

endmodule

// File: hdl/fft_bf.sv
`timescale 1ns/1ns

`include "fft_cfg.svh"

module fft_bf #(
   parameter fft_ctrl_pkg::stage_t STAGE = '0
) (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  logic                    en_i,
   input  fft_ctrl_pkg::ctr_t      ctr_i,
   output fft_ctrl_pkg::ctr_t      ctr_o,
   input  fft_sample_pkg::sample_t x_re_i,
   input  fft_sample_pkg::sample_t x_im_i,
   output fft_sample_pkg::sample_t z_re_o,
   output fft_sample_pkg::sample_t z_im_o
);

   import fft_ctrl_pkg::*;
   import fft_sample_pkg::*;

   localparam int   S         = int'(STAGE);
   localparam int   SEL1_BIT  = `FFT_LOG2N - 1 - 2 * S;
   localparam int   SEL2_BIT  = `FFT_LOG2N - 2 - 2 * S;
   localparam ctr_t CTRII_LAG = ctr_t'(2 ** SEL1_BIT + 1);  // bfi delay line plus its register.

   logic    sel1;
   logic    sel2;
   logic    tsel;
   logic    start_ctrii;
   logic    start_ctr_o;
   ctr_t    ctrii;  // position of the sample entering bfii.
   sample_t bfi_re;
   sample_t bfi_im;

   assign sel1 = ctr_i[SEL1_BIT];
   assign sel2 = ctrii[SEL2_BIT];
   assign tsel = ctrii[SEL1_BIT];  // difference half of the bfi output.

   fft_bfi #(
      .DELAY_LEN (2 ** SEL1_BIT)
   ) u_bfi (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .en_i     (en_i),
      .sel_i    (sel1),
      .x_re_i   (x_re_i),
      .x_im_i   (x_im_i),
      .z_re_o   (bfi_re),
      .z_im_o   (bfi_im)
   );

   fft_bfii #(
      .DELAY_LEN (2 ** SEL2_BIT)
   ) u_bfii (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .en_i     (en_i),
      .sel_i    (sel2),
      .tsel_i   (tsel),
      .x_re_i   (bfi_re),
      .x_im_i   (bfi_im),
      .z_re_o   (z_re_o),
      .z_im_o   (z_im_o)
   );

   // each counter starts one cycle after its select first rises.
   // that is when the first result leaves the butterfly register.
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         start_ctrii <= 1'b0;
         start_ctr_o <= 1'b0;
         ctrii       <= '0;
         ctr_o       <= '0;
      end else if (en_i) begin
         if (sel1) start_ctrii <= 1'b1;
         if (start_ctrii) ctrii <= ctrii + 1'b1;
         if (sel2) start_ctr_o <= 1'b1;
         if (start_ctr_o) ctr_o <= ctr_o + 1'b1;
      end
   end

   a_ctrii_lag: assert property (@(posedge clk) disable iff (!arst_n_i)
      start_ctrii |-> (ctrii == ctr_t'(ctr_i - CTRII_LAG)));

endmodule

// File: hdl/fft_twiddle.sv
`timescale 1ns/1ns

`include "fft_cfg.svh"

module fft_twiddle (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  logic                    en_i,
   input  fft_ctrl_pkg::ctr_t      ctr_i,
   output fft_ctrl_pkg::ctr_t      ctr_o,
   input  fft_sample_pkg::sample_t x_re_i,
   input  fft_sample_pkg::sample_t x_im_i,
   output fft_sample_pkg::sample_t z_re_o,
   output fft_sample_pkg::sample_t z_im_o
);

   import fft_sample_pkg::*;
   import fft_ctrl_pkg::*;

   localparam int SHIFT = `FFT_TW_WIDTH - 2;

   // W16^e with e = bitrev(ctr[3:2]) * ctr[1:0], so per block of four:
   // e = 0,0,0,0 / 0,2,4,6 / 0,1,2,3 / 0,3,6,9.
   // W = cos(2*pi*e/16) - j*sin(2*pi*e/16), scaled by 1024.
   localparam twiddle_t TW_RE [`FFT_N] = '{
      1024, 1024, 1024, 1024,
      1024,  724,    0, -724,
      1024,  946,  724,  392,
      1024,  392, -724, -946
   };
   localparam twiddle_t TW_IM [`FFT_N] = '{
      0,     0,     0,     0,
      0,  -724, -1024,  -724,
      0,  -392,  -724,  -946,
      0,  -946,  -724,   392
   };

   twiddle_t w_re;
   twiddle_t w_im;
   prod_t    p_rr;
   prod_t    p_ii;
   prod_t    p_ri;
   prod_t    p_ir;
   acc_t     acc_re;
   acc_t     acc_im;
   sample_t  x_re_p;  // input aligned with the products.
   sample_t  x_im_p;
   ctr_t     ctr_p;

   assign w_re = TW_RE[ctr_i];
   assign w_im = TW_IM[ctr_i];

   assign acc_re = acc_t'(p_rr) - acc_t'(p_ii);
   assign acc_im = acc_t'(p_ri) + acc_t'(p_ir);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         p_rr   <= '0;
         p_ii   <= '0;
         p_ri   <= '0;
         p_ir   <= '0;
         x_re_p <= '0;
         x_im_p <= '0;
         ctr_p  <= '0;
         z_re_o <= '0;
         z_im_o <= '0;
         ctr_o  <= '0;
      end else if (en_i) begin
         p_rr   <= x_re_i * w_re;  // rom read and multiply.
         p_ii   <= x_im_i * w_im;
         p_ri   <= x_re_i * w_im;
         p_ir   <= x_im_i * w_re;
         x_re_p <= x_re_i;
         x_im_p <= x_im_i;
         ctr_p  <= ctr_i;
         z_re_o <= sample_t'(acc_re >>> SHIFT);  // truncate, no rounding.
         z_im_o <= sample_t'(acc_im >>> SHIFT);
         ctr_o  <= ctr_p;
      end
   end

   a_unity: assert property (@(posedge clk) disable iff (!arst_n_i)
      (en_i && ctr_p == '0) |=> (z_re_o == $past(x_re_p) && z_im_o == $past(x_im_p)));

endmodule

// File: hdl/fft_sdf16.sv
`timescale 1ns/1ns

`include "fft_cfg.svh"

module fft_sdf16 (
   input  logic                    clk,
   input  logic                    arst_n_i,
   input  logic                    in_valid_i,
   input  fft_sample_pkg::sample_t x_re_i,
   input  fft_sample_pkg::sample_t x_im_i,
   output logic                    out_valid_o,
   output fft_ctrl_pkg::ctr_t      out_index_o,
   output fft_sample_pkg::sample_t y_re_o,
   output fft_sample_pkg::sample_t y_im_o
);

   import fft_sample_pkg::*;
   import fft_ctrl_pkg::*;

   ctr_t    in_ctr;
   fill_t   fill_cnt;
   logic    primed;
   ctr_t    out_pos;  // natural-order position of the output sample.
   ctr_t    s0_ctr;
   ctr_t    tw_ctr;
   ctr_t    s1_ctr;
   sample_t s0_re;
   sample_t s0_im;
   sample_t tw_re;
   sample_t tw_im;
   sample_t s1_re;
   sample_t s1_im;

   fft_bf #(.STAGE(stage_t'(0))) u_bf0 (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .en_i     (in_valid_i),
      .ctr_i    (in_ctr),
      .ctr_o    (s0_ctr),
      .x_re_i   (x_re_i),
      .x_im_i   (x_im_i),
      .z_re_o   (s0_re),
      .z_im_o   (s0_im)
   );

   fft_twiddle u_tw (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .en_i     (in_valid_i),
      .ctr_i    (s0_ctr),
      .ctr_o    (tw_ctr),
      .x_re_i   (s0_re),
      .x_im_i   (s0_im),
      .z_re_o   (tw_re),
      .z_im_o   (tw_im)
   );

   fft_bf #(.STAGE(stage_t'(1))) u_bf1 (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .en_i     (in_valid_i),
      .ctr_i    (tw_ctr),
      .ctr_o    (s1_ctr),
      .x_re_i   (tw_re),
      .x_im_i   (tw_im),
      .z_re_o   (s1_re),
      .z_im_o   (s1_im)
   );

   assign out_index_o = {<<{out_pos}};  // frequency index.

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_ctr      <= '0;
         fill_cnt    <= '0;
         primed      <= 1'b0;
         out_valid_o <= 1'b0;
         out_pos     <= '0;
         y_re_o      <= '0;
         y_im_o      <= '0;
      end else begin
         out_valid_o <= in_valid_i && primed;
         if (in_valid_i) begin
            in_ctr <= in_ctr + 1'b1;
            if (!primed) fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt == fill_t'(`FFT_LATENCY - 2)) primed <= 1'b1;
            out_pos <= s1_ctr;
            y_re_o  <= s1_re;
            y_im_o  <= s1_im;
         end
      end
   end

   a_out_order: assert property (@(posedge clk) disable iff (!arst_n_i)
      (out_valid_o && $past(out_valid_o)) |-> (out_pos == ctr_t'($past(out_pos) + 1'b1)));

endmodule

// File: verif/fft_tb.sv
`timescale 1ns/1ns

`include "fft_cfg.svh"

module fft_tb;

   import fft_sample_pkg::*;
   import fft_ctrl_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int FRAMES       = 3;
   localparam int FLUSH_FRAMES = 2;
   localparam int NUM_OUT      = FRAMES * `FFT_N;
   // four clock cycles per sample leave room for the random gaps.
   localparam int TIMEOUT_NS   = (FRAMES + FLUSH_FRAMES) * `FFT_N * 4 * CLK_PERIOD;

   logic    clk;
   logic    arst_n;
   logic    in_valid;
   sample_t x_re;
   sample_t x_im;
   logic    out_valid;
   ctr_t    out_index;
   sample_t y_re;
   sample_t y_im;

   sample_t in_re  [NUM_OUT];
   sample_t in_im  [NUM_OUT];
   sample_t exp_re [NUM_OUT];  // kept in output order.
   sample_t exp_im [NUM_OUT];
   int      num_lines;
   int      accepted;
   int      out_count;
   int      value_errs;
   int      order_errs;
   int      timing_errs;
   integer  seed;

   fft_sdf16 uut (
      .clk         (clk),
      .arst_n_i    (arst_n),
      .in_valid_i  (in_valid),
      .x_re_i      (x_re),
      .x_im_i      (x_im),
      .out_valid_o (out_valid),
      .out_index_o (out_index),
      .y_re_o      (y_re),
      .y_im_o      (y_im)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic ctr_t bit_reverse(input int pos);
      ctr_t r;
      for (int b = 0; b < `FFT_LOG2N; b++)
         r[b] = pos[`FFT_LOG2N-1-b];
      return r;
   endfunction

   task automatic read_stimulus();
      integer          fd;
      integer          rc;
      int              n;
      int              v_in_re;
      int              v_in_im;
      int              v_ex_re;
      int              v_ex_im;
      logic [8*80-1:0] line;
      num_lines = 0;
      fd = $fopen("verif/fft_stim.txt", "r");
      if (fd == 0) return;
      while (!$feof(fd) && num_lines < NUM_OUT) begin
         line = '0;
         rc = $fgets(line, fd);
         n = (rc > 0) ? $sscanf(line, "%d %d %d %d", v_in_re, v_in_im, v_ex_re, v_ex_im) : 0;
         if (n == 4) begin  // comment lines give no numbers.
            in_re[num_lines]  = sample_t'(v_in_re);
            in_im[num_lines]  = sample_t'(v_in_im);
            exp_re[num_lines] = sample_t'(v_ex_re);
            exp_im[num_lines] = sample_t'(v_ex_im);
            num_lines++;
         end
      end
      $fclose(fd);
   endtask

   initial begin
      int idx;
      seed        = 32'h54e6;
      clk         = 1'b0;
      arst_n      = 1'b0;
      in_valid    = 1'b0;
      x_re        = '0;
      x_im        = '0;
      accepted    = 0;
      out_count   = 0;
      value_errs  = 0;
      order_errs  = 0;
      timing_errs = 0;
      idx         = 0;
      read_stimulus();
      if (num_lines != NUM_OUT) begin
         $display("stimulus file gave %0d usable lines, %0d needed", num_lines, NUM_OUT);
         $display("TEST FAIL");
         $finish;
      end else begin
         repeat (4) @(posedge clk);
         arst_n <= 1'b1;
         @(posedge clk);
         while (out_count < NUM_OUT) begin
            @(posedge clk);
            if (($random(seed) & 3) == 0) begin
               in_valid <= 1'b0;  // gap, about one cycle in four.
            end else begin
               in_valid <= 1'b1;
               x_re     <= (idx < NUM_OUT) ? in_re[idx] : '0;  // zeros flush the pipeline.
               x_im     <= (idx < NUM_OUT) ? in_im[idx] : '0;
               idx++;
            end
         end
         in_valid <= 1'b0;
         repeat (2) @(posedge clk);
         $display("errors: %0d value, %0d order, %0d timing", value_errs, order_errs,
                  timing_errs);
         if (value_errs + order_errs + timing_errs == 0) begin
            $display("TEST PASS");
         end else begin
            $display("TEST FAIL");
         end
         $finish;
      end
   end

   // outputs settle after the rising edge, so they are checked on the falling one.
   always @(negedge clk) begin
      int pos;
      if (arst_n && out_valid && out_count < NUM_OUT) begin
         pos = out_count % `FFT_N;
         assert (accepted >= `FFT_N) else begin
            $display("output valid at %0t after only %0d accepted samples", $time, accepted);
            timing_errs++;
         end
         assert (out_count == accepted - `FFT_LATENCY) else begin
            $display("output %0d left at %0t after %0d accepted samples, expected after %0d",
                     out_count, $time, accepted, out_count + `FFT_LATENCY);
            timing_errs++;
         end
         assert (out_index == bit_reverse(pos)) else begin
            $display("FAIL t=%0t out_index_o expected %0d got %0d", $time, bit_reverse(pos),
                     out_index);
            order_errs++;
         end
         assert (y_re == exp_re[out_count]) else begin
            $display("FAIL t=%0t y_re_o expected %0d got %0d", $time, exp_re[out_count], y_re);
            value_errs++;
         end
         assert (y_im == exp_im[out_count]) else begin
            $display("FAIL t=%0t y_im_o expected %0d got %0d", $time, exp_im[out_count], y_im);
            value_errs++;
         end
         out_count++;
      end
      if (arst_n && in_valid)
         accepted++;  // taken by the next rising edge.
   end

   initial begin
      #(TIMEOUT_NS);
      $display("watchdog expired after %0d ns, only %0d of %0d outputs arrived",
               TIMEOUT_NS, out_count, NUM_OUT);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: verilog.f
+incdir+hdl
hdl/fft_sample_pkg.sv
hdl/fft_ctrl_pkg.sv
hdl/fft_bfi.sv
hdl/fft_bfii.sv
hdl/fft_bf.sv
hdl/fft_twiddle.sv
hdl/fft_sdf16.sv
verif/fft_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the FFT testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
   -f verilog.f --top-module fft_tb -o fft_sim \
   && ./obj_dir/fft_sim | tee /dev/stderr | grep -qx "TEST PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: verif/fft_stim.txt
# columns: in_re in_im exp_re exp_im, one sample per line.
# expected parts are listed in output order (bit-reversed index).
# frame 0: impulse of 1234 - j567 at sample 0.
1234 -567 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
0 0 1234 -567
# frame 1: constant 100 - j50.
100 -50 1600 -800
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
100 -50 0 0
# frame 2: real impulse of 1000 at sample 1, twiddles truncated.
0 0 1000 0
1000 0 -1000 0
0 0 0 -1000
0 0 0 1000
0 0 707 -708
0 0 -707 708
0 0 -708 -707
0 0 708 707
0 0 923 -383
0 0 -923 383
0 0 -383 -923
0 0 383 923
0 0 382 -924
0 0 -382 924
0 0 -924 -382
0 0 924 382
